//--- files.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/mem_ctrl.sv
rtl/axi_dual_sram.sv
rtl/mem_subsys.sv
sim/tb_mem_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_mem_subsys
FILELIST  := files.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --timescale 1ns/1ps -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_mem_subsys.sv
`include "mem_defs.svh"

module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam word_t BASE    = 32'h8000_0200;
    localparam int    WORDS   = 32;
    localparam int    N_FILL  = 2 * WORDS;
    localparam int    N_RAND  = 200;
    localparam int    N_FETCH = WORDS;
    localparam int    N_MIX   = 100;
    localparam int    N_OPS   = N_FILL + N_RAND + N_FETCH + 2 * N_MIX;
    localparam int    LIMIT   = N_OPS * (2 * `SRAM_LAT + 10);

    logic     clk;
    logic     rst;
    word_t    fetch_addr;
    logic     fetch_en;
    word_t    fetch_data;
    logic     fetch_done;
    lsu_req_t lsu_req;
    logic     lsu_r_en;
    logic     lsu_w_en;
    word_t    lsu_rdata;
    logic     lsu_done;

    // byte model of the test region
    logic [7:0] model_mem [WORDS*4];
    int seed;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int fetch_reqs = 0;
    int lsu_reqs = 0;
    int fetch_dones = 0;
    int lsu_dones = 0;

    mem_subsys UUT (
        .clk       (clk),
        .rst       (rst),
        .fetch_addr(fetch_addr),
        .fetch_en  (fetch_en),
        .fetch_data(fetch_data),
        .fetch_done(fetch_done),
        .lsu_req   (lsu_req),
        .lsu_r_en  (lsu_r_en),
        .lsu_w_en  (lsu_w_en),
        .lsu_rdata (lsu_rdata),
        .lsu_done  (lsu_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // count every cycle a done is seen high
    always @(posedge clk) begin
        if (!rst) begin
            if (fetch_done) begin
                fetch_dones = fetch_dones + 1;
            end
            if (lsu_done) begin
                lsu_dones = lsu_dones + 1;
            end
        end
    end

    function automatic word_t rand_word();
        word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic word_t make_addr(input int idx, input logic [1:0] off);
        return BASE + (word_t'(idx) << 2) + word_t'(off);
    endfunction

    function automatic logic [6:0] byte_index(input int idx, input int lane);
        return 7'(idx * 4 + lane);
    endfunction

    function automatic word_t model_word(input int idx);
        return {model_mem[byte_index(idx, 3)], model_mem[byte_index(idx, 2)],
                model_mem[byte_index(idx, 1)], model_mem[byte_index(idx, 0)]};
    endfunction

    // byte b of wdata lands in lane b + off, lanes past 3 are lost
    function automatic void model_store(input int idx, input logic [1:0] off,
                                        input word_t wdata, input mask_t mask);
        for (int b = 0; b < 4; b++) begin
            if (mask[b] && b + int'(off) < 4) begin
                model_mem[byte_index(idx, b + int'(off))] = wdata[8*b +: 8];
            end
        end
    endfunction

    function automatic word_t expect_load(input int idx, input logic [1:0] off);
        word_t w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            if (i + int'(off) < 4) begin
                w[8*i +: 8] = model_mem[byte_index(idx, i + int'(off))];
            end
        end
        return w;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic do_fetch(input int idx, input logic [1:0] off, output word_t data);
        @(posedge clk);
        fetch_addr <= make_addr(idx, off);
        fetch_en   <= 1'b1;
        @(posedge clk);
        fetch_en <= 1'b0;
        while (!fetch_done) @(posedge clk);
        fetch_reqs = fetch_reqs + 1;
        data = fetch_data;
    endtask

    task automatic lsu_store(input int idx, input logic [1:0] off,
                             input word_t wdata, input mask_t mask);
        @(posedge clk);
        lsu_req  <= {make_addr(idx, off), wdata, mask};
        lsu_w_en <= 1'b1;
        @(posedge clk);
        lsu_w_en <= 1'b0;
        while (!lsu_done) @(posedge clk);
        lsu_reqs = lsu_reqs + 1;
        model_store(idx, off, wdata, mask);
    endtask

    task automatic lsu_load(input int idx, input logic [1:0] off, output word_t data);
        @(posedge clk);
        lsu_req  <= {make_addr(idx, off), rand_word(), mask_t'(rand_word())};
        lsu_r_en <= 1'b1;
        @(posedge clk);
        lsu_r_en <= 1'b0;
        while (!lsu_done) @(posedge clk);
        lsu_reqs = lsu_reqs + 1;
        data = lsu_rdata;
    endtask

    initial begin
        word_t r;
        word_t got;
        int idx;
        seed       = 32'hdb109317;
        rst        = 1'b1;
        fetch_addr = '0;
        fetch_en   = 1'b0;
        lsu_req    = '0;
        lsu_r_en   = 1'b0;
        lsu_w_en   = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // idle outputs before any request
        repeat (6) begin
            @(posedge clk);
            check_flag("fetch_done", fetch_done, 1'b0);
            check_flag("lsu_done", lsu_done, 1'b0);
            check_word("fetch_data", fetch_data, '0);
            check_word("lsu_rdata", lsu_rdata, '0);
        end
        end_test(1, "reset state");

        for (int i = 0; i < WORDS; i++) begin
            lsu_store(i, 2'd0, rand_word(), 4'hf);
        end
        for (int i = 0; i < WORDS; i++) begin
            lsu_load(i, 2'd0, got);
            check_word("lsu_rdata", got, model_word(i));
        end
        end_test(2, "aligned store and load");

        for (int n = 0; n < N_RAND; n++) begin
            r   = rand_word();
            idx = int'(r[4:0]);
            if (r[7]) begin
                lsu_store(idx, r[6:5], rand_word(), r[11:8]);
            end else begin
                lsu_load(idx, r[6:5], got);
                check_word("lsu_rdata", got, expect_load(idx, r[6:5]));
            end
        end
        end_test(3, "unaligned masked store and load");

        for (int i = 0; i < N_FETCH; i++) begin
            r = rand_word();
            do_fetch(i, r[1:0], got);
            check_word("fetch_data", got, model_word(i));
        end
        end_test(4, "fetch after store");

        // lsu on words 0 to 15, fetch on words 16 to 31
        fork
            begin : mix_lsu
                word_t lr;
                word_t lgot;
                int lidx;
                for (int n = 0; n < N_MIX; n++) begin
                    lr   = rand_word();
                    lidx = int'(lr[3:0]);
                    if (lr[7]) begin
                        lsu_store(lidx, lr[6:5], rand_word(), lr[11:8]);
                    end else begin
                        lsu_load(lidx, lr[6:5], lgot);
                        check_word("lsu_rdata", lgot, expect_load(lidx, lr[6:5]));
                    end
                end
            end
            begin : mix_fetch
                word_t fr;
                word_t fgot;
                int fidx;
                for (int n = 0; n < N_MIX; n++) begin
                    fr   = rand_word();
                    fidx = 16 + int'(fr[3:0]);
                    do_fetch(fidx, fr[5:4], fgot);
                    check_word("fetch_data", fgot, model_word(fidx));
                end
            end
        join
        repeat (3) @(posedge clk);
        check_count("fetch_done pulses", fetch_dones, fetch_reqs);
        check_count("lsu_done pulses", lsu_dones, lsu_reqs);
        end_test(5, "mixed traffic");

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/mem_subsys.sv
module mem_subsys (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::word_t    fetch_addr,
    input  logic              fetch_en,
    output mem_pkg::word_t    fetch_data,
    output logic              fetch_done,
    input  mem_pkg::lsu_req_t lsu_req,
    input  logic              lsu_r_en,
    input  logic              lsu_w_en,
    output mem_pkg::word_t    lsu_rdata,
    output logic              lsu_done
);
    import mem_pkg::*;

    ar_chan_t m1_ar;
    r_chan_t  m1_r;
    logic     m1_arvalid;
    logic     m1_arready;
    logic     m1_rvalid;
    logic     m1_rready;
    ar_chan_t m2_ar;
    r_chan_t  m2_r;
    aw_chan_t m2_aw;
    w_chan_t  m2_w;
    logic     m2_arvalid;
    logic     m2_arready;
    logic     m2_rvalid;
    logic     m2_rready;
    logic     m2_awvalid;
    logic     m2_awready;
    logic     m2_wvalid;
    logic     m2_wready;
    logic     m2_bvalid;
    logic     m2_bready;

    mem_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .fetch_addr(fetch_addr),
        .fetch_en  (fetch_en),
        .fetch_data(fetch_data),
        .fetch_done(fetch_done),
        .lsu_req   (lsu_req),
        .lsu_r_en  (lsu_r_en),
        .lsu_w_en  (lsu_w_en),
        .lsu_rdata (lsu_rdata),
        .lsu_done  (lsu_done),
        .m1_ar     (m1_ar),
        .m1_arvalid(m1_arvalid),
        .m1_arready(m1_arready),
        .m1_r      (m1_r),
        .m1_rvalid (m1_rvalid),
        .m1_rready (m1_rready),
        .m2_ar     (m2_ar),
        .m2_arvalid(m2_arvalid),
        .m2_arready(m2_arready),
        .m2_r      (m2_r),
        .m2_rvalid (m2_rvalid),
        .m2_rready (m2_rready),
        .m2_aw     (m2_aw),
        .m2_awvalid(m2_awvalid),
        .m2_awready(m2_awready),
        .m2_w      (m2_w),
        .m2_wvalid (m2_wvalid),
        .m2_wready (m2_wready),
        .m2_bvalid (m2_bvalid),
        .m2_bready (m2_bready)
    );

    // fetch on port 1, load/store on port 2
    axi_dual_sram u_sram (
        .clk       (clk),
        .rst       (rst),
        .s1_ar     (m1_ar),
        .s1_arvalid(m1_arvalid),
        .s1_arready(m1_arready),
        .s1_r      (m1_r),
        .s1_rvalid (m1_rvalid),
        .s1_rready (m1_rready),
        .s2_ar     (m2_ar),
        .s2_arvalid(m2_arvalid),
        .s2_arready(m2_arready),
        .s2_r      (m2_r),
        .s2_rvalid (m2_rvalid),
        .s2_rready (m2_rready),
        .s2_aw     (m2_aw),
        .s2_awvalid(m2_awvalid),
        .s2_awready(m2_awready),
        .s2_w      (m2_w),
        .s2_wvalid (m2_wvalid),
        .s2_wready (m2_wready),
        .s2_bvalid (m2_bvalid),
        .s2_bready (m2_bready)
    );

endmodule

//--- rtl/axi_dual_sram.sv
`include "mem_defs.svh"

module axi_dual_sram (
    input  logic              clk,
    input  logic              rst,

    input  mem_pkg::ar_chan_t s1_ar,
    input  logic              s1_arvalid,
    output logic              s1_arready,
    output mem_pkg::r_chan_t  s1_r,
    output logic              s1_rvalid,
    input  logic              s1_rready,

    input  mem_pkg::ar_chan_t s2_ar,
    input  logic              s2_arvalid,
    output logic              s2_arready,
    output mem_pkg::r_chan_t  s2_r,
    output logic              s2_rvalid,
    input  logic              s2_rready,
    input  mem_pkg::aw_chan_t s2_aw,
    input  logic              s2_awvalid,
    output logic              s2_awready,
    input  mem_pkg::w_chan_t  s2_w,
    input  logic              s2_wvalid,
    output logic              s2_wready,
    output logic              s2_bvalid,
    input  logic              s2_bready
);
    import mem_pkg::*;

    localparam int IDX_W = `SRAM_ADDR_BITS;
    localparam int LAT   = `SRAM_LAT;
    localparam int CNT_W = $clog2(LAT + 1);

    typedef enum logic [1:0] {
        WR_COLLECT,
        WR_WAIT,
        WR_RESP
    } wr_state_t;

    word_t mem [2**IDX_W];

    // both read ports side by side
    ar_chan_t rd_ar      [2];
    logic     rd_arvalid [2];
    logic     rd_arready [2];
    r_chan_t  rd_r       [2];
    logic     rd_rvalid  [2];
    logic     rd_rready  [2];

    wr_state_t          wr_state;
    logic [CNT_W-1:0]   wr_cnt;
    logic               aw_got;
    logic               w_got;
    logic               wr_commit;
    logic [IDX_W-1:0]   wr_idx;
    w_chan_t            wr_w;

    assign rd_ar[0]      = s1_ar;
    assign rd_ar[1]      = s2_ar;
    assign rd_arvalid[0] = s1_arvalid;
    assign rd_arvalid[1] = s2_arvalid;
    assign rd_rready[0]  = s1_rready;
    assign rd_rready[1]  = s2_rready;
    assign s1_arready    = rd_arready[0];
    assign s2_arready    = rd_arready[1];
    assign s1_r          = rd_r[0];
    assign s2_r          = rd_r[1];
    assign s1_rvalid     = rd_rvalid[0];
    assign s2_rvalid     = rd_rvalid[1];

    for (genvar g = 0; g < 2; g++) begin : g_rd
        logic             busy;
        logic [CNT_W-1:0] cnt;
        logic [IDX_W-1:0] idx;
        logic [IDX_W-1:0] fire_idx;
        logic             ar_hs;
        logic             fire;
        logic             rvalid_q;
        r_chan_t          r_q;

        // idle engine takes a new address
        assign rd_arready[g] = !busy;
        assign ar_hs         = rd_arvalid[g] && !busy;
        assign fire          = (ar_hs && LAT == 1) || (cnt == CNT_W'(1));
        assign fire_idx      = ar_hs ? rd_ar[g].addr[IDX_W+1:2] : idx;
        assign rd_r[g]       = r_q;
        assign rd_rvalid[g]  = rvalid_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                busy     <= 1'b0;
                cnt      <= '0;
                rvalid_q <= 1'b0;
            end else begin
                if (ar_hs) begin
                    busy <= 1'b1;
                    cnt  <= CNT_W'(LAT - 1);
                end else if (cnt != '0) begin
                    cnt <= cnt - 1'b1;
                end
                if (fire) begin
                    rvalid_q <= 1'b1;
                end else if (rvalid_q && rd_rready[g]) begin
                    rvalid_q <= 1'b0;
                    busy     <= 1'b0;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (ar_hs) begin
                idx <= rd_ar[g].addr[IDX_W+1:2];
            end
            if (fire) begin
                r_q.data <= mem[fire_idx];
            end
        end

        // response and its data held until taken
        a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
            rvalid_q && !rd_rready[g] |=> rvalid_q && $stable(r_q));
    end

    // write engine, aw and w may arrive in either order
    assign s2_awready = !aw_got;
    assign s2_wready  = !w_got;
    assign s2_bvalid  = (wr_state == WR_RESP);
    assign wr_commit  = (wr_state == WR_COLLECT) && aw_got && w_got;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= WR_COLLECT;
            wr_cnt   <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
        end else begin
            if (s2_awvalid && s2_awready) begin
                aw_got <= 1'b1;
            end
            if (s2_wvalid && s2_wready) begin
                w_got <= 1'b1;
            end
            case (wr_state)
                WR_COLLECT: begin
                    if (wr_commit) begin
                        if (LAT == 1) begin
                            wr_state <= WR_RESP;
                        end else begin
                            wr_state <= WR_WAIT;
                            wr_cnt   <= CNT_W'(LAT - 1);
                        end
                    end
                end
                WR_WAIT: begin
                    wr_cnt <= wr_cnt - 1'b1;
                    if (wr_cnt == CNT_W'(1)) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (s2_bready) begin
                        wr_state <= WR_COLLECT;
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                    end
                end
                default: wr_state <= WR_COLLECT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (s2_awvalid && s2_awready) begin
            wr_idx <= s2_aw.addr[IDX_W+1:2];
        end
        if (s2_wvalid && s2_wready) begin
            wr_w <= s2_w;
        end
        // strobed byte write
        if (wr_commit) begin
            for (int b = 0; b < $bits(mask_t); b++) begin
                if (wr_w.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_w.data[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- rtl/mem_ctrl.sv
module mem_ctrl (
    input  logic              clk,
    input  logic              rst,

    input  mem_pkg::word_t    fetch_addr,
    input  logic              fetch_en,
    output mem_pkg::word_t    fetch_data,
    output logic              fetch_done,

    input  mem_pkg::lsu_req_t lsu_req,
    input  logic              lsu_r_en,
    input  logic              lsu_w_en,
    output mem_pkg::word_t    lsu_rdata,
    output logic              lsu_done,

    output mem_pkg::ar_chan_t m1_ar,
    output logic              m1_arvalid,
    input  logic              m1_arready,
    input  mem_pkg::r_chan_t  m1_r,
    input  logic              m1_rvalid,
    output logic              m1_rready,

    output mem_pkg::ar_chan_t m2_ar,
    output logic              m2_arvalid,
    input  logic              m2_arready,
    input  mem_pkg::r_chan_t  m2_r,
    input  logic              m2_rvalid,
    output logic              m2_rready,
    output mem_pkg::aw_chan_t m2_aw,
    output logic              m2_awvalid,
    input  logic              m2_awready,
    output mem_pkg::w_chan_t  m2_w,
    output logic              m2_wvalid,
    input  logic              m2_wready,
    input  logic              m2_bvalid,
    output logic              m2_bready
);
    import mem_pkg::*;

    logic  m1_ar_hs;
    logic  m1_r_hs;
    logic  m2_ar_hs;
    logic  m2_r_hs;
    logic  m2_aw_hs;
    logic  m2_w_hs;
    logic  m2_b_hs;
    logic  [1:0] lsu_off;
    word_t lsu_load;
    logic  fetch_busy;
    logic  lsu_busy;

    assign m1_ar_hs = m1_arvalid && m1_arready;
    assign m1_r_hs  = m1_rvalid && m1_rready;
    assign m2_ar_hs = m2_arvalid && m2_arready;
    assign m2_r_hs  = m2_rvalid && m2_rready;
    assign m2_aw_hs = m2_awvalid && m2_awready;
    assign m2_w_hs  = m2_wvalid && m2_wready;
    assign m2_b_hs  = m2_bvalid && m2_bready;

    // fetch port, read only
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            m1_ar.addr <= fetch_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m1_arvalid <= 1'b0;
            m1_rready  <= 1'b0;
        end else begin
            if (m1_ar_hs) begin
                m1_arvalid <= 1'b0;
            end else if (fetch_en) begin
                m1_arvalid <= 1'b1;
            end
            if (m1_r_hs) begin
                m1_rready <= 1'b0;
            end else if (m1_ar_hs) begin
                m1_rready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_data <= '0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= m1_r_hs;
            if (m1_r_hs) begin
                fetch_data <= m1_r.data;
            end
        end
    end

    // load/store payloads, word aligned address and lane shifted data
    always_ff @(posedge clk) begin
        if (lsu_r_en) begin
            m2_ar.addr <= {lsu_req.addr[$bits(word_t)-1:2], 2'b00};
            lsu_off    <= lsu_req.addr[1:0];
        end
        if (lsu_w_en) begin
            m2_aw.addr <= {lsu_req.addr[$bits(word_t)-1:2], 2'b00};
            m2_w.data  <= lsu_req.wdata << {lsu_req.addr[1:0], 3'b000};
            // lanes past byte 3 fall off
            m2_w.strb  <= mask_t'(lsu_req.mask << lsu_req.addr[1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m2_arvalid <= 1'b0;
            m2_rready  <= 1'b0;
            m2_awvalid <= 1'b0;
            m2_wvalid  <= 1'b0;
            m2_bready  <= 1'b0;
        end else begin
            if (m2_ar_hs) begin
                m2_arvalid <= 1'b0;
            end else if (lsu_r_en) begin
                m2_arvalid <= 1'b1;
            end
            if (m2_r_hs) begin
                m2_rready <= 1'b0;
            end else if (m2_ar_hs) begin
                m2_rready <= 1'b1;
            end
            if (m2_aw_hs) begin
                m2_awvalid <= 1'b0;
            end else if (lsu_w_en) begin
                m2_awvalid <= 1'b1;
            end
            if (m2_w_hs) begin
                m2_wvalid <= 1'b0;
            end else if (lsu_w_en) begin
                m2_wvalid <= 1'b1;
            end
            if (m2_b_hs) begin
                m2_bready <= 1'b0;
            end else if (m2_aw_hs) begin
                m2_bready <= 1'b1;
            end
        end
    end

    // zero fill from the top
    assign lsu_load = m2_r.data >> {lsu_off, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            lsu_rdata <= '0;
            lsu_done  <= 1'b0;
        end else begin
            lsu_done <= m2_r_hs || m2_b_hs;
            if (m2_r_hs) begin
                lsu_rdata <= lsu_load;
            end
        end
    end

    // one request in flight per client
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_busy <= 1'b0;
            lsu_busy   <= 1'b0;
        end else begin
            if (fetch_en) begin
                fetch_busy <= 1'b1;
            end else if (m1_r_hs) begin
                fetch_busy <= 1'b0;
            end
            if (lsu_r_en || lsu_w_en) begin
                lsu_busy <= 1'b1;
            end else if (m2_r_hs || m2_b_hs) begin
                lsu_busy <= 1'b0;
            end
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        !(fetch_en && fetch_busy) && !((lsu_r_en || lsu_w_en) && lsu_busy));

    a_lsu_excl: assert property (@(posedge clk) disable iff (rst)
        !(lsu_r_en && lsu_w_en));

endmodule

//--- rtl/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    typedef logic [`MEM_XLEN-1:0] word_t;
    typedef logic [`MEM_MASK_W-1:0] mask_t;

    // axi-lite channel payloads, resp fields left out
    typedef struct packed {
        word_t addr;
    } ar_chan_t;

    typedef struct packed {
        word_t data;
    } r_chan_t;

    typedef struct packed {
        word_t addr;
    } aw_chan_t;

    typedef struct packed {
        word_t data;
        mask_t strb;
    } w_chan_t;

    // load/store client request, byte addressed
    typedef struct packed {
        word_t addr;
        word_t wdata;
        mask_t mask;
    } lsu_req_t;

endpackage

//--- rtl/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data and address width
`define MEM_XLEN 32

// one strobe bit per byte lane
`define MEM_MASK_W 4

// word index bits of the shared array, 1024 words
`define SRAM_ADDR_BITS 10

// cycles from address handshake to response valid, must be 1 or more
`define SRAM_LAT 3

`endif
